//--- src/mipsPkg.sv
package mipsPkg;

	// widths that carry a meaning
	typedef logic [31:0] wordT;
	typedef logic [31:0] addrT;
	typedef logic [4:0]  regIdxT;
	// execute operand source
	typedef logic [1:0]  fwdSelT;

	localparam fwdSelT fwdReg = 2'd0;
	localparam fwdSelT fwdWb  = 2'd1;
	localparam fwdSelT fwdMem = 2'd2;

	// primary opcodes of the subset
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opJ       = 6'h02,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opAddiu   = 6'h09,
		opOri     = 6'h0d,
		opLui     = 6'h0f,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeT;

	// funct field of special ops
	localparam logic [5:0] functAddu = 6'h21;
	localparam logic [5:0] functSubu = 6'h23;
	localparam logic [5:0] functAnd  = 6'h24;
	localparam logic [5:0] functOr   = 6'h25;
	localparam logic [5:0] functSlt  = 6'h2a;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOpT;

	// decoded controls, all zero is a no-op
	typedef struct packed {
		logic  regWrite;
		logic  memToReg;
		logic  memWrite;
		logic  aluSrcImm;
		logic  regDstRd;
		logic  isBranch;
		logic  branchNe;
		logic  isJump;
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		logic en;
		logic we;
		addrT addr;
		wordT wdata;
	} dmemReqT;

	// one retired register write
	typedef struct packed {
		logic   valid;
		addrT   pc;
		regIdxT regNum;
		wordT   data;
	} wbTraceT;

endpackage

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
	input  logic   clk,
	input  logic   arstN,
	input  logic   we,
	input  regIdxT wa,
	input  wordT   wd,
	input  regIdxT ra1,
	input  regIdxT ra2,
	output wordT   rd1,
	output wordT   rd2
);

	wordT regs [32];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// r0 reads zero, same-cycle write passes straight to decode
	assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

//--- src/instDecode.sv
`timescale 1ns/1ps

module instDecode import mipsPkg::*; (
	input  wordT instr,
	input  addrT pcPlus4,
	output ctrlT ctrl,
	output wordT imm,
	output addrT jumpTarget
);

	opcodeT     op;
	logic [5:0] funct;

	assign op    = opcodeT'(instr[31:26]);
	assign funct = instr[5:0];

	always_comb begin
		ctrl = '0;
		case (op)
			opSpecial: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				case (funct)
					functAddu: ctrl.aluOp = aluAdd;
					functSubu: ctrl.aluOp = aluSub;
					functAnd:  ctrl.aluOp = aluAnd;
					functOr:   ctrl.aluOp = aluOr;
					functSlt:  ctrl.aluOp = aluSlt;
					// sll and friends are not supported
					default:   ctrl = '0;
				endcase
			end
			opAddiu: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opOri: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = aluOr;
			end
			opLui: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = aluLui;
			end
			opLw: begin
				ctrl.regWrite  = 1'b1;
				ctrl.memToReg  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opSw: begin
				ctrl.memWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opBeq: ctrl.isBranch = 1'b1;
			opBne: begin
				ctrl.isBranch = 1'b1;
				ctrl.branchNe = 1'b1;
			end
			opJ: ctrl.isJump = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// ori is the only zero-extended immediate
	assign imm = (op == opOri) ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	// 256MB region of the delay-slot address
	assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

endmodule

//--- src/execUnit.sv
`timescale 1ns/1ps

module execUnit import mipsPkg::*; (
	input  wordT  srcA,
	input  wordT  srcB,
	input  wordT  rtVal,
	input  aluOpT aluOp,
	input  logic  isBranch,
	input  logic  branchNe,
	output wordT  aluOut,
	output logic  taken
);

	logic eq;

	always_comb begin
		case (aluOp)
			aluAdd:  aluOut = srcA + srcB;
			aluSub:  aluOut = srcA - srcB;
			aluAnd:  aluOut = srcA & srcB;
			aluOr:   aluOut = srcA | srcB;
			// signed compare
			aluSlt:  aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
			// immediate into upper half
			aluLui:  aluOut = {srcB[15:0], 16'b0};
			default: aluOut = srcA + srcB;
		endcase
	end

	// branch compare on forwarded rs and rt
	assign eq    = (srcA == rtVal);
	assign taken = isBranch & (branchNe ? ~eq : eq);

endmodule

//--- src/branchPredictor.sv
`timescale 1ns/1ps

module branchPredictor import mipsPkg::*; #(
	parameter int PRED_ENTRIES = 64
) (
	input  logic clk,
	input  logic arstN,
	input  logic hold,
	input  addrT pcF,
	output logic predictF,
	input  logic updateEn,
	input  addrT pcE,
	input  logic takenE
);

	localparam int IDX_W = $clog2(PRED_ENTRIES);

	typedef logic [IDX_W-1:0] idxT;
	// 2'b01 is weakly not-taken
	typedef logic [1:0] ctrT;

	ctrT counters [PRED_ENTRIES];
	idxT idxF;
	idxT idxE;

	// word address bits, byte offset dropped
	assign idxF = pcF[IDX_W+1:2];
	assign idxE = pcE[IDX_W+1:2];

	// msb is the prediction
	assign predictF = counters[idxF][1];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < PRED_ENTRIES; i++)
				counters[i] <= 2'b01;
		end else if (updateEn && !hold) begin
			// saturate at both ends
			if (takenE && counters[idxE] != 2'b11)
				counters[idxE] <= counters[idxE] + 2'd1;
			else if (!takenE && counters[idxE] != 2'b00)
				counters[idxE] <= counters[idxE] - 2'd1;
		end
	end

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
	input  logic   iStall,
	input  logic   dStall,
	input  regIdxT rsD, rtD, rsE, rtE,
	input  regIdxT writeRegE, writeRegM, writeRegW,
	input  logic   regWriteE, regWriteM, regWriteW,
	input  logic   memToRegE,
	input  logic   jumpD,
	input  logic   mispredictE,
	output logic   stallF, stallD, flushD, flushE,
	output logic   freeze,
	output fwdSelT fwdAE, fwdBE
);

	logic loadUse;

	// newest producer wins, so memory stage before writeback
	function automatic fwdSelT pickFwd(
		input regIdxT src,
		input regIdxT wrM,
		input logic   weM,
		input regIdxT wrW,
		input logic   weW
	);
		if (src == '0)
			return fwdReg;
		if (weM && wrM == src)
			return fwdMem;
		if (weW && wrW == src)
			return fwdWb;
		return fwdReg;
	endfunction

	assign fwdAE = pickFwd(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
	assign fwdBE = pickFwd(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

	// load in execute feeding decode, data not ready until writeback
	assign loadUse = regWriteE & memToRegE & (writeRegE != '0)
		& ((writeRegE == rsD) | (writeRegE == rtD));

	// either memory stall freezes every stage
	assign freeze = iStall | dStall;

	assign stallF = freeze | loadUse;
	assign stallD = freeze | loadUse;

	// a jump held by the interlock redirects one cycle later
	assign flushD = ~freeze & (mispredictE | (jumpD & ~loadUse));
	// bubble into execute
	assign flushE = ~freeze & (mispredictE | loadUse);

endmodule

//--- src/pipeDatapath.sv
`timescale 1ns/1ps

module pipeDatapath import mipsPkg::*; #(
	parameter int PRED_ENTRIES = 64
) (
	input  logic    clk,
	input  logic    arstN,
	output addrT    pc,
	input  wordT    instr,
	output dmemReqT dmemReq,
	input  wordT    readData,
	output wbTraceT wbTrace,
	input  logic    stallF, stallD, flushD, flushE, freeze,
	input  fwdSelT  fwdAE, fwdBE,
	output regIdxT  rsD, rtD, rsE, rtE,
	output regIdxT  writeRegE, writeRegM, writeRegW,
	output logic    regWriteE, regWriteM, regWriteW,
	output logic    memToRegE, jumpD, mispredictE
);

	typedef struct packed {
		addrT pc;
		wordT instr;
		logic pred;
	} ifIdT;

	typedef struct packed {
		ctrlT   ctrl;
		addrT   pc;
		addrT   brTarget;
		wordT   rsVal;
		wordT   rtVal;
		wordT   imm;
		regIdxT rs;
		regIdxT rt;
		regIdxT writeReg;
		logic   pred;
	} idExT;

	typedef struct packed {
		ctrlT   ctrl;
		addrT   pc;
		wordT   aluOut;
		wordT   storeData;
		regIdxT writeReg;
	} exMemT;

	typedef struct packed {
		logic   regWrite;
		addrT   pc;
		regIdxT writeReg;
		wordT   result;
	} memWbT;

	ifIdT  dReg;
	idExT  eReg;
	exMemT mReg;
	memWbT wReg;

	addrT   pcPlus4F, brTargetF, nextPc;
	logic   predictF, predTakenF;
	ctrlT   ctrlD;
	wordT   immD, rsValD, rtValD;
	addrT   pcPlus4D, brTargetD, jumpTargetD;
	wordT   srcAE, rtFwdE, srcBE, aluOutE;
	logic   takenE;
	wordT   resultM;

	function automatic wordT fwdMux(
		input fwdSelT sel,
		input wordT   regVal,
		input wordT   memVal,
		input wordT   wbVal
	);
		case (sel)
			fwdMem:  return memVal;
			fwdWb:   return wbVal;
			default: return regVal;
		endcase
	endfunction

	// fetch, branch predecoded straight from the fetched word
	assign pcPlus4F   = pc + 32'd4;
	assign brTargetF  = pcPlus4F + {{14{instr[15]}}, instr[15:0], 2'b00};
	assign predTakenF = predictF & (instr[31:26] == opBeq || instr[31:26] == opBne);

	branchPredictor #(
		.PRED_ENTRIES(PRED_ENTRIES)
	) uBranchPredictor (
		.clk(clk),
		.arstN(arstN),
		.hold(freeze),
		.pcF(pc),
		.predictF(predictF),
		.updateEn(eReg.ctrl.isBranch),
		.pcE(eReg.pc),
		.takenE(takenE)
	);

	// recovery first, then jump, then prediction
	always_comb begin
		if (mispredictE)
			nextPc = takenE ? eReg.brTarget : eReg.pc + 32'd4;
		else if (jumpD)
			nextPc = jumpTargetD;
		else if (predTakenF)
			nextPc = brTargetF;
		else
			nextPc = pcPlus4F;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			pc <= '0;
		else if (!stallF)
			pc <= nextPc;
	end

	// a cleared instruction word decodes as a no-op
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN || flushD)
			dReg <= '0;
		else if (!stallD)
			dReg <= '{pc: pc, instr: instr, pred: predTakenF};
	end

	// decode
	assign rsD      = dReg.instr[25:21];
	assign rtD      = dReg.instr[20:16];
	assign pcPlus4D = dReg.pc + 32'd4;
	assign jumpD    = ctrlD.isJump;
	// kept for recovery in execute
	assign brTargetD = pcPlus4D + {immD[29:0], 2'b00};

	instDecode uInstDecode (
		.instr(dReg.instr),
		.pcPlus4(pcPlus4D),
		.ctrl(ctrlD),
		.imm(immD),
		.jumpTarget(jumpTargetD)
	);

	// written from writeback
	regFile uRegFile (
		.clk(clk),
		.arstN(arstN),
		.we(wReg.regWrite & ~freeze),
		.wa(wReg.writeReg),
		.wd(wReg.result),
		.ra1(rsD),
		.ra2(rtD),
		.rd1(rsValD),
		.rd2(rtValD)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN || flushE)
			eReg <= '0;
		else if (!freeze)
			eReg <= '{ctrl: ctrlD, pc: dReg.pc, brTarget: brTargetD,
				rsVal: rsValD, rtVal: rtValD, imm: immD, rs: rsD, rt: rtD,
				writeReg: ctrlD.regDstRd ? dReg.instr[15:11] : rtD, pred: dReg.pred};
	end

	// execute
	assign rsE       = eReg.rs;
	assign rtE       = eReg.rt;
	assign writeRegE = eReg.writeReg;
	assign regWriteE = eReg.ctrl.regWrite;
	assign memToRegE = eReg.ctrl.memToReg;

	assign srcAE  = fwdMux(fwdAE, eReg.rsVal, mReg.aluOut, wReg.result);
	assign rtFwdE = fwdMux(fwdBE, eReg.rtVal, mReg.aluOut, wReg.result);
	assign srcBE  = eReg.ctrl.aluSrcImm ? eReg.imm : rtFwdE;

	execUnit uExecUnit (
		.srcA(srcAE),
		.srcB(srcBE),
		.rtVal(rtFwdE),
		.aluOp(eReg.ctrl.aluOp),
		.isBranch(eReg.ctrl.isBranch),
		.branchNe(eReg.ctrl.branchNe),
		.aluOut(aluOutE),
		.taken(takenE)
	);

	// pred is only set for branches
	assign mispredictE = eReg.ctrl.isBranch & (takenE != eReg.pred);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			mReg <= '0;
		else if (!freeze)
			mReg <= '{ctrl: eReg.ctrl, pc: eReg.pc, aluOut: aluOutE,
				storeData: rtFwdE, writeReg: eReg.writeReg};
	end

	// memory, request held steady while frozen
	assign writeRegM = mReg.writeReg;
	assign regWriteM = mReg.ctrl.regWrite;
	assign dmemReq   = '{en: mReg.ctrl.memWrite | mReg.ctrl.memToReg,
		we: mReg.ctrl.memWrite, addr: mReg.aluOut, wdata: mReg.storeData};
	assign resultM   = mReg.ctrl.memToReg ? readData : mReg.aluOut;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			wReg <= '0;
		else if (!freeze)
			wReg <= '{regWrite: mReg.ctrl.regWrite, pc: mReg.pc,
				writeReg: mReg.writeReg, result: resultM};
	end

	// writeback, retire only on a cycle that advances
	assign writeRegW = wReg.writeReg;
	assign regWriteW = wReg.regWrite;
	assign wbTrace   = '{valid: wReg.regWrite & ~freeze, pc: wReg.pc,
		regNum: wReg.writeReg, data: wReg.result};

endmodule

//--- src/coreTop.sv
`timescale 1ns/1ps

module coreTop import mipsPkg::*; #(
	parameter int PRED_ENTRIES = 64
) (
	input  logic    clk,
	input  logic    arstN,
	output addrT    pc,
	input  wordT    instr,
	input  logic    iStall,
	output dmemReqT dmemReq,
	input  wordT    readData,
	input  logic    dStall,
	output wbTraceT wbTrace,
	output logic    freeze
);

	// control from hazard unit
	logic   stallF;
	logic   stallD;
	logic   flushD;
	logic   flushE;
	fwdSelT fwdAE;
	fwdSelT fwdBE;

	// pipeline state seen by hazard unit
	regIdxT rsD;
	regIdxT rtD;
	regIdxT rsE;
	regIdxT rtE;
	regIdxT writeRegE;
	regIdxT writeRegM;
	regIdxT writeRegW;
	logic   regWriteE;
	logic   regWriteM;
	logic   regWriteW;
	logic   memToRegE;
	logic   jumpD;
	logic   mispredictE;

	// port names match on both sides
	hazardUnit uHazardUnit (.*);

	pipeDatapath #(
		.PRED_ENTRIES(PRED_ENTRIES)
	) uPipeDatapath (.*);

endmodule

//--- dv/coreTop_asserts.sv
`timescale 1ns/1ps

module coreTop_asserts import mipsPkg::*; (
	input logic    clk,
	input logic    arstN,
	input logic    iStall,
	input dmemReqT dmemReq,
	input logic    dStall,
	input wbTraceT wbTrace,
	input logic    freeze
);

	// stalled access presented unchanged on the next edge
	reqHeldOnStall: assert property (
		@(posedge clk) disable iff (!arstN)
		dStall |=> $stable(dmemReq)
	) else $error("data request changed while dStall was high");

	// nothing retires while either memory stalls
	noTraceOnStall: assert property (
		@(posedge clk) disable iff (!arstN)
		(iStall || dStall) |-> !wbTrace.valid
	) else $error("trace valid while a memory stall was high");

	// reset keeps writeback quiet
	noTraceInReset: assert property (
		@(posedge clk)
		!arstN |-> !wbTrace.valid
	) else $error("trace valid during reset");

endmodule

//--- dv/tbTop.sv
`timescale 1ns/1ps

module tbTop import mipsPkg::*; ();

	localparam int clkPeriod      = 100;
	localparam int resetCycles    = 4;
	// watchdog budget per retirement
	localparam int cyclesPerEntry = 20;
	// quiet cycles after the last retirement
	localparam int drainCycles    = 20;
	localparam int stallOneIn     = 8;
	localparam int seed           = 58276;
	localparam int imemWords      = 64;
	localparam int dmemWords      = 64;
	localparam int imemAw         = $clog2(imemWords);
	localparam int dmemAw         = $clog2(dmemWords);
	localparam int stimWords      = 128;
	localparam int maxEntries     = 40;

	logic    clk;
	logic    arstN;
	addrT    pc;
	wordT    instr;
	logic    iStall;
	dmemReqT dmemReq;
	wordT    readData;
	logic    dStall;
	wbTraceT wbTrace;
	logic    freeze;

	wordT   stim [stimWords];
	wordT   imem [imemWords];
	wordT   dmem [dmemWords];
	addrT   expPc [maxEntries];
	regIdxT expReg [maxEntries];
	wordT   expData [maxEntries];
	int     numProg = 0;
	int     numExp = 0;
	int     seen = 0;

	coreTop #(
		.PRED_ENTRIES(64)
	) u_coreTop (.*);

	bind coreTop coreTop_asserts uCoreTopAsserts (.*);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// fetch answers in the same cycle, junk while the word is not ready
	assign instr = iStall ? 32'hffff_ffff : imem[pc[imemAw+1:2]];
	assign readData = dStall ? 32'hffff_ffff : dmem[dmemReq.addr[dmemAw+1:2]];

	// data memory, refilled during reset, write lands when the access completes
	always @(posedge clk) begin
		if (!arstN) begin
			for (int i = 0; i < dmemWords; i++)
				dmem[i] <= 32'hda7a_0000 ^ (32'(i) << 2);
		end else if (dmemReq.en && dmemReq.we && !dStall) begin
			dmem[dmemReq.addr[dmemAw+1:2]] <= dmemReq.wdata;
		end
	end

	// about one stall cycle in eight on each side, same process as the seed
	initial begin
		void'($urandom(seed));
		forever begin
			@(posedge clk);
			iStall <= ($urandom() % stallOneIn) == 0;
			dStall <= ($urandom() % stallOneIn) == 0;
		end
	end

	task automatic endWithFailure();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkAddr(input string what, input addrT expVal, input addrT gotVal);
		if (gotVal !== expVal) begin
			$display("Mismatch at %0t: entry %0d %s expected %h, got %h",
				$time, seen, what, expVal, gotVal);
			endWithFailure();
		end
	endtask

	task automatic checkReg(input string what, input regIdxT expVal, input regIdxT gotVal);
		if (gotVal !== expVal) begin
			$display("Mismatch at %0t: entry %0d %s expected %0d, got %0d",
				$time, seen, what, expVal, gotVal);
			endWithFailure();
		end
	endtask

	task automatic checkWord(input string what, input wordT expVal, input wordT gotVal);
		if (gotVal !== expVal) begin
			$display("Mismatch at %0t: entry %0d %s expected %h, got %h",
				$time, seen, what, expVal, gotVal);
			endWithFailure();
		end
	endtask

	task automatic checkFlag(input string what, input logic expVal, input logic gotVal);
		if (gotVal !== expVal) begin
			$display("Mismatch at %0t: %s expected %b, got %b",
				$time, what, expVal, gotVal);
			endWithFailure();
		end
	endtask

	// header words, then program, then pc/register/value triples
	task automatic loadStimulus();
		int base;
		$readmemh("dv/coreStim.txt", stim);
		if ($isunknown(stim[0]) || $isunknown(stim[1])) begin
			$display("stimulus file dv/coreStim.txt is missing or has no header");
			endWithFailure();
		end
		numProg = int'(stim[0]);
		numExp = int'(stim[1]);
		if (numProg > imemWords || numExp > maxEntries || numExp == 0
				|| 2 + numProg + 3 * numExp > stimWords) begin
			$display("stimulus file sizes do not fit the testbench memories");
			endWithFailure();
		end
		// unused words decode as a no-op, tagged with their own address
		for (int i = 0; i < imemWords; i++)
			imem[i] = 32'hfc00_0000 | (32'(i) << 2);
		for (int i = 0; i < numProg; i++)
			imem[i] = stim[2 + i];
		base = 2 + numProg;
		for (int i = 0; i < numExp; i++) begin
			expPc[i] = stim[base + 3 * i];
			expReg[i] = regIdxT'(stim[base + 3 * i + 1]);
			expData[i] = stim[base + 3 * i + 2];
		end
	endtask

	// freeze is high exactly while either memory stalls
	always @(negedge clk) begin
		if (arstN)
			checkFlag("freeze", iStall | dStall, freeze);
	end

	initial begin
		arstN = 1'b0;
		iStall = 1'b0;
		dStall = 1'b0;
		loadStimulus();
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
		// trace is steady mid-cycle
		while (seen < numExp) begin
			@(negedge clk);
			if (wbTrace.valid) begin
				checkAddr("pc", expPc[seen], wbTrace.pc);
				checkReg("register", expReg[seen], wbTrace.regNum);
				checkWord("value", expData[seen], wbTrace.data);
				seen++;
			end
		end
		// program parks in a jump loop, nothing else may retire
		repeat (drainCycles) begin
			@(negedge clk);
			if (wbTrace.valid) begin
				$display("unexpected retirement after the last entry, pc %h", wbTrace.pc);
				endWithFailure();
			end
		end
		$display("Simulation passed");
		$finish;
	end

	// watchdog
	initial begin
		wait (numExp > 0);
		#(clkPeriod * (cyclesPerEntry * numExp + resetCycles));
		$display("timeout, only %0d of %0d retirements seen", seen, numExp);
		endWithFailure();
	end

endmodule

//--- dv/coreStim.txt
// header: program word count, expected trace entry count (hex)
1a
18
// program words from address 0
// constants, lui then ori, then signed operands
3c011234
3421abcd
2402fffb
24030003
// slt both ways, subu, and, or, addu
0043202a
0062282a
00823023
00223824
00e64025
01034821
// base address, store, load back, load-use addu
240a0040
ad490004
8d4b0004
016b6021
// counter and sum, then bne loop at 0x48
240d0004
240e0000
25ce0005
25adffff
15a0fffd
// j over two words
08000016
240f0111
24100222
25cf0001
// taken beq skips one word, then park in a jump loop
11ef0001
24100333
08000019
// expected trace, columns: pc register value
00000000 01 12340000
00000004 01 1234abcd
00000008 02 fffffffb
0000000c 03 00000003
00000010 04 00000001
00000014 05 00000000
00000018 06 00000006
0000001c 07 1234abc9
00000020 08 1234abcf
00000024 09 1234abd2
00000028 0a 00000040
00000030 0b 1234abd2
00000034 0c 246957a4
00000038 0d 00000004
0000003c 0e 00000000
00000040 0e 00000005
00000044 0d 00000003
00000040 0e 0000000a
00000044 0d 00000002
00000040 0e 0000000f
00000044 0d 00000001
00000040 0e 00000014
00000044 0d 00000000
00000058 0f 00000015

//--- src.f
src/mipsPkg.sv
src/regFile.sv
src/instDecode.sv
src/execUnit.sv
src/branchPredictor.sv
src/hazardUnit.sv
src/pipeDatapath.sv
src/coreTop.sv
dv/coreTop_asserts.sv
dv/tbTop.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbTop -f src.f -o tbTop
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/tbTop)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "Simulation passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
